// File: Bender.yml
package:
  name: rp_lock

sources:
  - common/rp_sample_pkg.sv
  - common/rp_ctrl_pkg.sv
  - hdl/rp_adc_frontend.sv
  - pid/rp_pid_channel.sv
  - limit/rp_output_limiter.sv
  - hdl/rp_dac_formatter.sv
  - hdl/rp_lock_top.sv
  - target: test
    files:
      - testbench/rp_lock_properties.sv
      - testbench/tb_rp_lock_top.sv

// File: common/rp_ctrl_pkg.sv
// controller and limiter configuration, status flags, DAC phase
package rp_ctrl_pkg;

  //////////////////////////////
  // gains and accumulator
  //////////////////////////////

  localparam int GAIN_W    = 16;  // unsigned gain
  localparam int PID_SHIFT = 12;  // 4096 is unity gain
  localparam int INTEG_W   = 28;  // integrator accumulator
  localparam int PROD_W    = rp_sample_pkg::SUM_W + GAIN_W + 1;  // error x gain

  typedef logic        [GAIN_W-1:0]  gain_t;
  typedef logic signed [INTEG_W-1:0] integ_t;

  // integrator saturation limits
  localparam integ_t INTEG_MAX = {1'b0, {(INTEG_W-1){1'b1}}};
  localparam integ_t INTEG_MIN = {1'b1, {(INTEG_W-1){1'b0}}};

  //////////////////////////////
  // per channel configuration
  //////////////////////////////

  typedef struct packed {
    logic                   enable;    // 0 clears integrator, output zero
    rp_sample_pkg::sample_t setpoint;
    gain_t                  kp;        // proportional gain
    gain_t                  ki;        // integral gain
  } pid_cfg_t;

  typedef struct packed {
    rp_sample_pkg::sample_t offset;  // static offset, generator stand-in
    rp_sample_pkg::sample_t lo;      // lower clamp
    rp_sample_pkg::sample_t hi;      // upper clamp
  } limit_cfg_t;

  // limiter status, feeds anti-windup
  typedef struct packed {
    logic high;
    logic low;
  } railed_t;

  // interleave phase, select line high on A
  typedef enum logic {
    PHASE_B = 1'b0,
    PHASE_A = 1'b1
  } dac_phase_e;

endpackage

// File: common/rp_sample_pkg.sv
// sample path widths and types, shared by every stage
package rp_sample_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int NUM_CH    = 2;   // channels A and B
  localparam int ADC_RAW_W = 16;  // ADC word incl. reserved low bits
  localparam int SAMPLE_W  = 14;  // signal width end to end
  localparam int SUM_W     = 15;  // one guard bit for offset sum

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // raw ADC pins
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // two's complement
  typedef logic signed [SUM_W-1:0]     sum_t;       // before saturation
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // unsigned, negative slope

  // full scale of a sample
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};  // +8191
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};  // -8192

  // DAC code for a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};  // 14'h1FFF

endpackage

// File: hdl/rp_adc_frontend.sv
`timescale 1ns/1ps

// ADC capture, slope conversion and digital loop mux
module rp_adc_frontend (
  input  logic                                                adc_clk,
  input  logic                                                rst_n_i,
  input  rp_sample_pkg::adc_raw_t [rp_sample_pkg::NUM_CH-1:0] adc_dat_i,      // raw ADC words
  input  rp_sample_pkg::sample_t  [rp_sample_pkg::NUM_CH-1:0] loop_dat_i,     // limiter outputs
  input  logic                                                digital_loop_i, // bypass ADC
  output rp_sample_pkg::sample_t  [rp_sample_pkg::NUM_CH-1:0] sample_o
);

rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] adc_cnv;   // converted ADC
rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] sample_d;  // register input
rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] sample_q;

//////////////////////////////
// slope conversion
//////////////////////////////

// drop two reserved LSBs, keep sign, flip magnitude bits
always_comb
begin
  for (int ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin
    adc_cnv[ch]  = {adc_dat_i[ch][rp_sample_pkg::ADC_RAW_W-1],
                    ~adc_dat_i[ch][rp_sample_pkg::ADC_RAW_W-2:2]};
    sample_d[ch] = digital_loop_i ? loop_dat_i[ch] : adc_cnv[ch];  // loop adds one cycle
  end
end

//////////////////////////////
// capture register
//////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    sample_q <= '0;
  end
  else
  begin
    sample_q <= sample_d;
  end
end

assign sample_o = sample_q;

endmodule

// File: hdl/rp_dac_formatter.sv
`timescale 1ns/1ps

// DAC code conversion and A/B interleave on one bus
module rp_dac_formatter (
  input  logic                                               adc_clk,
  input  logic                                               rst_n_i,
  input  rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] lim_i,     // [0] = A, [1] = B
  output rp_sample_pkg::dac_code_t                           dac_dat_o, // interleaved code
  output logic                                               dac_sel_o  // high on channel A
);

rp_sample_pkg::dac_code_t [rp_sample_pkg::NUM_CH-1:0] code_d;
rp_sample_pkg::dac_code_t [rp_sample_pkg::NUM_CH-1:0] code_q;
rp_ctrl_pkg::dac_phase_e                              phase_q;

//////////////////////////////
// signed -> negative slope
//////////////////////////////

always_comb
begin
  for (int ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin
    code_d[ch] = {lim_i[ch][rp_sample_pkg::SAMPLE_W-1],
                  ~lim_i[ch][rp_sample_pkg::SAMPLE_W-2:0]};
  end
end

//////////////////////////////
// code registers and phase
//////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    code_q  <= {rp_sample_pkg::NUM_CH{rp_sample_pkg::DAC_ZERO}};  // zero output
    phase_q <= rp_ctrl_pkg::PHASE_B;   // first A cycle one clock after release
  end
  else
  begin
    code_q  <= code_d;   // both channels every cycle
    phase_q <= (phase_q == rp_ctrl_pkg::PHASE_A) ? rp_ctrl_pkg::PHASE_B
                                                 : rp_ctrl_pkg::PHASE_A;
  end
end

// bus mux, A while select is high
assign dac_sel_o = (phase_q == rp_ctrl_pkg::PHASE_A);
assign dac_dat_o = dac_sel_o ? code_q[0] : code_q[1];

endmodule

// File: hdl/rp_lock_top.sv
`timescale 1ns/1ps

// two channel lock controller, analog path only
// ADC -> frontend -> PI -> limiter -> DAC formatter, limiter feeds back
module rp_lock_top (
  input  logic                                                 adc_clk,
  input  logic                                                 rst_n_i,
  // ADC
  input  rp_sample_pkg::adc_raw_t   [rp_sample_pkg::NUM_CH-1:0] adc_dat_i,
  // configuration
  input  logic                                                 digital_loop_i,
  input  rp_ctrl_pkg::pid_cfg_t     [rp_sample_pkg::NUM_CH-1:0] pid_cfg_i,
  input  rp_ctrl_pkg::limit_cfg_t   [rp_sample_pkg::NUM_CH-1:0] limit_cfg_i,
  // DAC
  output rp_sample_pkg::dac_code_t                             dac_dat_o,
  output logic                                                 dac_sel_o,
  // status
  output rp_ctrl_pkg::railed_t      [rp_sample_pkg::NUM_CH-1:0] railed_o
);

rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] adc_sample;  // frontend out
rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] pid_dat;     // controller out
rp_sample_pkg::sample_t [rp_sample_pkg::NUM_CH-1:0] lim_dat;     // limited, to DAC and loop
rp_ctrl_pkg::railed_t   [rp_sample_pkg::NUM_CH-1:0] railed;      // limiter status

//////////////////////////////
// ADC side
//////////////////////////////

rp_adc_frontend i_frontend (
  .adc_clk        (adc_clk       ),
  .rst_n_i        (rst_n_i       ),
  .adc_dat_i      (adc_dat_i     ),
  .loop_dat_i     (lim_dat       ),  // digital loop source
  .digital_loop_i (digital_loop_i),
  .sample_o       (adc_sample    )
);

//////////////////////////////
// per channel PI and limit
//////////////////////////////

generate
  for (genvar ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin : g_ch
    rp_pid_channel i_pid (
      .adc_clk  (adc_clk       ),
      .rst_n_i  (rst_n_i       ),
      .sample_i (adc_sample[ch]),
      .cfg_i    (pid_cfg_i[ch] ),
      .railed_i (railed[ch]    ),  // anti-windup
      .ctrl_o   (pid_dat[ch]   )
    );

    rp_output_limiter i_limit (
      .adc_clk  (adc_clk        ),
      .rst_n_i  (rst_n_i        ),
      .ctrl_i   (pid_dat[ch]    ),
      .cfg_i    (limit_cfg_i[ch]),
      .lim_o    (lim_dat[ch]    ),
      .railed_o (railed[ch]     )
    );
  end
endgenerate

assign railed_o = railed;

//////////////////////////////
// DAC side
//////////////////////////////

rp_dac_formatter i_dac (
  .adc_clk   (adc_clk  ),
  .rst_n_i   (rst_n_i  ),
  .lim_i     (lim_dat  ),
  .dac_dat_o (dac_dat_o),
  .dac_sel_o (dac_sel_o)
);

endmodule

// File: limit/rp_output_limiter.sv
`timescale 1ns/1ps

// offset add, 14 bit saturation and range clamp for one channel
module rp_output_limiter (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  rp_sample_pkg::sample_t  ctrl_i,    // controller output
  input  rp_ctrl_pkg::limit_cfg_t cfg_i,
  output rp_sample_pkg::sample_t  lim_o,     // limited value
  output rp_ctrl_pkg::railed_t    railed_o   // at hi / at lo
);

rp_sample_pkg::sum_t    sum;       // ctrl + offset
rp_sample_pkg::sample_t sat;       // saturated sum
rp_sample_pkg::sample_t clamp;     // clamped into lo..hi
rp_ctrl_pkg::railed_t   railed_d;
rp_sample_pkg::sample_t lim_q;
rp_ctrl_pkg::railed_t   railed_q;

//////////////////////////////
// sum and saturation
//////////////////////////////

// sign extend by one bit, no overflow at SUM_W
assign sum = {ctrl_i[rp_sample_pkg::SAMPLE_W-1], ctrl_i}
           + {cfg_i.offset[rp_sample_pkg::SAMPLE_W-1], cfg_i.offset};

// top two bits differ -> out of range
assign sat = (sum[rp_sample_pkg::SUM_W-1] ^ sum[rp_sample_pkg::SUM_W-2])
           ? {sum[rp_sample_pkg::SUM_W-1], {(rp_sample_pkg::SAMPLE_W-1){~sum[rp_sample_pkg::SUM_W-1]}}}
           : sum[rp_sample_pkg::SAMPLE_W-1:0];

//////////////////////////////
// range clamp
//////////////////////////////

always_comb
begin
  if ($signed(sat) >= $signed(cfg_i.hi))
    clamp = cfg_i.hi;      // upper rail
  else if ($signed(sat) <= $signed(cfg_i.lo))
    clamp = cfg_i.lo;      // lower rail
  else
    clamp = sat;
end

// flags follow the clamped value
assign railed_d.high = $signed(clamp) >= $signed(cfg_i.hi);
assign railed_d.low  = $signed(clamp) <= $signed(cfg_i.lo);

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    lim_q    <= '0;
    railed_q <= '0;
  end
  else
  begin
    lim_q    <= clamp;
    railed_q <= railed_d;  // aligned with lim_q
  end
end

assign lim_o    = lim_q;
assign railed_o = railed_q;

endmodule

// File: pid/rp_pid_channel.sv
`timescale 1ns/1ps

// PI controller for one channel
// integrator holds while the limiter is railed in the direction it pushes
module rp_pid_channel (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  rp_sample_pkg::sample_t sample_i,  // measured value
  input  rp_ctrl_pkg::pid_cfg_t  cfg_i,
  input  rp_ctrl_pkg::railed_t   railed_i,  // from own limiter
  output rp_sample_pkg::sample_t ctrl_o     // control output
);

rp_sample_pkg::sum_t                       err;        // setpoint - sample
logic signed [rp_ctrl_pkg::PROD_W-1:0]     p_prod;     // err x kp
logic signed [rp_ctrl_pkg::PROD_W-1:0]     p_term;     // scaled back
logic signed [rp_ctrl_pkg::PROD_W-1:0]     i_inc;      // err x ki
logic signed [rp_ctrl_pkg::PROD_W:0]       integ_sum;  // one guard bit
logic signed [rp_ctrl_pkg::PROD_W-1:0]     ctrl_sum;
logic                                      i_freeze;
rp_ctrl_pkg::integ_t                       integ_d;
rp_ctrl_pkg::integ_t                       integ_q;
rp_sample_pkg::sample_t                    ctrl_d;
rp_sample_pkg::sample_t                    ctrl_q;

//////////////////////////////
// error and products
//////////////////////////////

// sign extend both, difference fits 15 bits
assign err = $signed({cfg_i.setpoint[rp_sample_pkg::SAMPLE_W-1], cfg_i.setpoint})
           - $signed({sample_i[rp_sample_pkg::SAMPLE_W-1], sample_i});

// gains are unsigned, zero extend
assign p_prod = err * $signed({1'b0, cfg_i.kp});
assign i_inc  = err * $signed({1'b0, cfg_i.ki});

assign p_term = p_prod >>> rp_ctrl_pkg::PID_SHIFT;

//////////////////////////////
// integrator
//////////////////////////////

// anti-windup, block growth into the railed side only
assign i_freeze = (railed_i.high && !i_inc[rp_ctrl_pkg::PROD_W-1] && (i_inc != '0))
               || (railed_i.low  &&  i_inc[rp_ctrl_pkg::PROD_W-1]);

assign integ_sum = integ_q + i_inc;

always_comb
begin
  if (!cfg_i.enable)
    integ_d = '0;                        // disabled, clear
  else if (i_freeze)
    integ_d = integ_q;                   // hold
  else if (integ_sum > rp_ctrl_pkg::INTEG_MAX)
    integ_d = rp_ctrl_pkg::INTEG_MAX;    // accumulator full
  else if (integ_sum < rp_ctrl_pkg::INTEG_MIN)
    integ_d = rp_ctrl_pkg::INTEG_MIN;
  else
    integ_d = integ_sum[rp_ctrl_pkg::INTEG_W-1:0];
end

//////////////////////////////
// output
//////////////////////////////

assign ctrl_sum = p_term + (integ_q >>> rp_ctrl_pkg::PID_SHIFT);

// saturate to sample range
always_comb
begin
  if (!cfg_i.enable)
    ctrl_d = '0;
  else if (ctrl_sum > rp_sample_pkg::SAMPLE_MAX)
    ctrl_d = rp_sample_pkg::SAMPLE_MAX;
  else if (ctrl_sum < rp_sample_pkg::SAMPLE_MIN)
    ctrl_d = rp_sample_pkg::SAMPLE_MIN;
  else
    ctrl_d = ctrl_sum[rp_sample_pkg::SAMPLE_W-1:0];
end

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    integ_q <= '0;
    ctrl_q  <= '0;
  end
  else
  begin
    integ_q <= integ_d;
    ctrl_q  <= ctrl_d;   // one cycle through the controller
  end
end

assign ctrl_o = ctrl_q;

endmodule

// File: rp_lock_top.f
common/rp_sample_pkg.sv
common/rp_ctrl_pkg.sv
hdl/rp_adc_frontend.sv
pid/rp_pid_channel.sv
limit/rp_output_limiter.sv
hdl/rp_dac_formatter.sv
hdl/rp_lock_top.sv
testbench/rp_lock_properties.sv
testbench/tb_rp_lock_top.sv

// File: testbench/rp_lock_properties.sv
`timescale 1ns/1ps

module rp_lock_properties (
  input  logic                                                 adc_clk,
  input  logic                                                 rst_n_i,
  input  rp_sample_pkg::adc_raw_t   [rp_sample_pkg::NUM_CH-1:0] adc_dat_i,
  input  logic                                                 digital_loop_i,
  input  rp_ctrl_pkg::pid_cfg_t     [rp_sample_pkg::NUM_CH-1:0] pid_cfg_i,
  input  rp_ctrl_pkg::limit_cfg_t   [rp_sample_pkg::NUM_CH-1:0] limit_cfg_i,
  input  rp_sample_pkg::dac_code_t                             dac_dat_o,
  input  logic                                                 dac_sel_o,
  input  rp_ctrl_pkg::railed_t      [rp_sample_pkg::NUM_CH-1:0] railed_o,
  input  rp_sample_pkg::sample_t    [rp_sample_pkg::NUM_CH-1:0] pid_dat_i   // controller outputs
);

int fail_cnt = 0;  // read by the testbench

rp_sample_pkg::adc_raw_t                            adc_h [4];  // channel A input history
rp_sample_pkg::adc_raw_t                            adc_hb [4]; // channel B input history
int                                                 dec_h [6];  // channel A output history
logic                                               rail_h [2]; // railed high history
logic                                               rail_l;     // railed low, one cycle back
rp_sample_pkg::sample_t                             ctrl_h;     // channel A controller, one back
rp_ctrl_pkg::pid_cfg_t   [rp_sample_pkg::NUM_CH-1:0] pid_prev;
rp_ctrl_pkg::limit_cfg_t [rp_sample_pkg::NUM_CH-1:0] lim_prev;
logic                                               loop_prev;
logic                                               sel_prev;
int                                                 fill_cnt;   // edges since reset release
int                                                 cfg_quiet;  // edges with unchanged config
int                                                 adc_quiet;  // edges with unchanged ADC
int                                                 dec_a;      // decoded channel A value
int                                                 exp_path;
int                                                 exp_path_b;
rp_sample_pkg::dac_code_t                           exp_code;   // code of the channel on the bus
int                                                 exp_loop;
int                                                 lo_a;
int                                                 hi_a;
logic                                               path_mode;
logic                                               wind_mode;
logic                                               loop_mode;

//////////////////////////////
// reference rules
//////////////////////////////

// ADC code, top 14 bits, negative slope
function automatic int adc_to_int(input rp_sample_pkg::adc_raw_t w);
  rp_sample_pkg::sample_t s;
  s = {w[15], ~w[14:2]};
  return int'(s);
endfunction

function automatic int sat14(input int v);
  if (v > 8191)
    return 8191;
  else if (v < -8192)
    return -8192;
  return v;
endfunction

function automatic int clamp_range(input int v, input int lo, input int hi);
  if (v >= hi)
    return hi;
  else if (v <= lo)
    return lo;
  return v;
endfunction

function automatic rp_sample_pkg::dac_code_t int_to_code(input int v);
  rp_sample_pkg::sample_t s;
  s = v[13:0];
  return {s[13], ~s[12:0]};  // sign kept, magnitude flipped
endfunction

function automatic int code_to_int(input rp_sample_pkg::dac_code_t c);
  rp_sample_pkg::sample_t s;
  s = {c[13], ~c[12:0]};
  return int'(s);
endfunction

// P only, unity gain, setpoint zero
function automatic logic p_only(input rp_ctrl_pkg::pid_cfg_t c);
  return c.enable && c.kp == 16'd4096 && c.ki == '0 && c.setpoint == '0;
endfunction

//////////////////////////////
// history and modes
//////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i)
begin
  if (!rst_n_i)
  begin
    adc_h     <= '{default: '0};
    adc_hb    <= '{default: '0};
    dec_h     <= '{default: 0};
    rail_h    <= '{default: 1'b0};
    rail_l    <= 1'b0;
    ctrl_h    <= '0;
    pid_prev  <= '0;
    lim_prev  <= '0;
    loop_prev <= 1'b0;
    sel_prev  <= 1'b0;
    fill_cnt  <= 0;
    cfg_quiet <= 0;
    adc_quiet <= 0;
  end
  else
  begin
    adc_h[0]  <= adc_dat_i[0];
    adc_hb[0] <= adc_dat_i[1];
    for (int i = 1; i < 4; i++)
    begin
      adc_h[i]  <= adc_h[i-1];
      adc_hb[i] <= adc_hb[i-1];
    end
    dec_h[0]  <= dec_a;
    for (int i = 1; i < 6; i++)
      dec_h[i] <= dec_h[i-1];
    rail_h[0] <= railed_o[0].high;
    rail_h[1] <= rail_h[0];
    rail_l    <= railed_o[0].low;
    ctrl_h    <= pid_dat_i[0];
    pid_prev  <= pid_cfg_i;
    lim_prev  <= limit_cfg_i;
    loop_prev <= digital_loop_i;
    sel_prev  <= dac_sel_o;
    fill_cnt  <= (fill_cnt < 15) ? fill_cnt + 1 : fill_cnt;
    if (pid_cfg_i != pid_prev || limit_cfg_i != lim_prev || digital_loop_i != loop_prev)
      cfg_quiet <= 0;                        // any config edit restarts
    else if (cfg_quiet < 15)
      cfg_quiet <= cfg_quiet + 1;
    if (adc_dat_i[0] != adc_h[0])
      adc_quiet <= 0;
    else if (adc_quiet < 15)
      adc_quiet <= adc_quiet + 1;
  end
end

always_comb
begin
  dec_a     = code_to_int(dac_dat_o);
  lo_a      = int'(lim_prev[0].lo);
  hi_a      = int'(lim_prev[0].hi);
  // both channels P only -> output is the negated sample
  path_mode = p_only(pid_prev[0]) && p_only(pid_prev[1]);
  wind_mode = pid_prev[0].enable && pid_prev[0].kp == '0 && pid_prev[0].ki != '0
           && int'(pid_prev[0].setpoint) > adc_to_int(adc_h[0]);   // positive error
  loop_mode = path_mode && loop_prev && lim_prev[0].offset == '0
           && lim_prev[0].lo == rp_sample_pkg::SAMPLE_MIN
           && lim_prev[0].hi == rp_sample_pkg::SAMPLE_MAX;
  exp_path  = clamp_range(sat14(sat14(-adc_to_int(adc_h[3])) + int'(lim_prev[0].offset)),
                          lo_a, hi_a);
  exp_path_b = clamp_range(sat14(sat14(-adc_to_int(adc_hb[3])) + int'(lim_prev[1].offset)),
                           int'(lim_prev[1].lo), int'(lim_prev[1].hi));
  exp_code  = int_to_code(dac_sel_o ? exp_path : exp_path_b);
  exp_loop  = sat14(-sat14(-dec_h[5]));  // two loop turns of three stages
end

//////////////////////////////
// proportional path, offset, saturation
//////////////////////////////

a_path: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (path_mode && !loop_prev && cfg_quiet >= 5) |-> dac_dat_o == exp_code)
  else
  begin
    fail_cnt++;
    $error("MISMATCH path exp %h act %h", $sampled(exp_code), $sampled(dac_dat_o));
  end

//////////////////////////////
// clamp and railed flags
//////////////////////////////

a_window: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (dac_sel_o && cfg_quiet >= 3 && fill_cnt >= 4) |-> (dec_a >= lo_a && dec_a <= hi_a))
  else
  begin
    fail_cnt++;
    $error("value %0d left the window %0d..%0d", $sampled(dec_a), $sampled(lo_a), $sampled(hi_a));
  end

a_rail_high: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (dac_sel_o && cfg_quiet >= 3 && fill_cnt >= 4) |-> rail_h[0] == (dec_a >= hi_a))
  else
  begin
    fail_cnt++;
    $error("MISMATCH rail_high exp %0b act %0b", $sampled(dec_a >= hi_a), $sampled(rail_h[0]));
  end

a_rail_low: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (dac_sel_o && cfg_quiet >= 3 && fill_cnt >= 4) |-> rail_l == (dec_a <= lo_a))
  else
  begin
    fail_cnt++;
    $error("MISMATCH rail_low exp %0b act %0b", $sampled(dec_a <= lo_a), $sampled(rail_l));
  end

// both channels
a_rail_excl: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (cfg_quiet >= 2) |-> !(railed_o[0].high && railed_o[0].low)
                    && !(railed_o[1].high && railed_o[1].low))
  else
  begin
    fail_cnt++;
    $error("railed high and low set at the same time");
  end

//////////////////////////////
// anti-windup
//////////////////////////////

a_wind_rise: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (dac_sel_o && wind_mode && cfg_quiet >= 8 && adc_quiet >= 8) |-> dec_a >= dec_h[1])
  else
  begin
    fail_cnt++;
    $error("output fell from %0d to %0d under positive error", $sampled(dec_h[1]),
           $sampled(dec_a));
  end

// controller itself, the clamp hides it on the DAC
a_wind_hold: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (wind_mode && cfg_quiet >= 8 && railed_o[0].high && rail_h[0] && rail_h[1])
  |-> pid_dat_i[0] <= ctrl_h)
  else
  begin
    fail_cnt++;
    $error("controller output rose from %0d to %0d while railed high", $sampled(ctrl_h),
           $sampled(pid_dat_i[0]));
  end

//////////////////////////////
// digital loop, interleave, reset
//////////////////////////////

// loop output depends only on its own past
a_loop: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (dac_sel_o && loop_mode && cfg_quiet >= 10) |-> dec_a == exp_loop)
  else
  begin
    fail_cnt++;
    $error("MISMATCH loop exp %0d act %0d", $sampled(exp_loop), $sampled(dec_a));
  end

a_sel_toggle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (fill_cnt >= 1) |-> dac_sel_o != sel_prev)
  else
  begin
    fail_cnt++;
    $error("dac_sel_o did not toggle");
  end

a_reset_dac: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (fill_cnt <= 3) |-> dac_dat_o == rp_sample_pkg::DAC_ZERO)
  else
  begin
    fail_cnt++;
    $error("MISMATCH reset_dac exp %h act %h", rp_sample_pkg::DAC_ZERO, $sampled(dac_dat_o));
  end

a_reset_railed: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
  (fill_cnt <= 2) |-> railed_o == '0)
  else
  begin
    fail_cnt++;
    $error("MISMATCH reset_railed exp 0 act %b", $sampled(railed_o));
  end

endmodule

bind rp_lock_top rp_lock_properties i_props (.*, .pid_dat_i(pid_dat));

// File: testbench/tb_rp_lock_top.sv
`timescale 1ns/1ps

module tb_rp_lock_top;

logic                                                 adc_clk;
logic                                                 rst_n_i;
rp_sample_pkg::adc_raw_t   [rp_sample_pkg::NUM_CH-1:0] adc_dat_i;
logic                                                 digital_loop_i;
rp_ctrl_pkg::pid_cfg_t     [rp_sample_pkg::NUM_CH-1:0] pid_cfg_i;
rp_ctrl_pkg::limit_cfg_t   [rp_sample_pkg::NUM_CH-1:0] limit_cfg_i;
rp_sample_pkg::dac_code_t                             dac_dat_o;
logic                                                 dac_sel_o;
rp_ctrl_pkg::railed_t      [rp_sample_pkg::NUM_CH-1:0] railed_o;

logic [31:0] rng_state = 32'd24;
int          timeout_cnt = 0;

rp_lock_top UUT (
  .adc_clk        (adc_clk       ),
  .rst_n_i        (rst_n_i       ),
  .adc_dat_i      (adc_dat_i     ),
  .digital_loop_i (digital_loop_i),
  .pid_cfg_i      (pid_cfg_i     ),
  .limit_cfg_i    (limit_cfg_i   ),
  .dac_dat_o      (dac_dat_o     ),
  .dac_sel_o      (dac_sel_o     ),
  .railed_o       (railed_o      )
);

initial adc_clk = 1'b0;
always #5 adc_clk = ~adc_clk;  // 100 MHz

//////////////////////////////
// helpers
//////////////////////////////

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// n cycles of random ADC words, both channels
task automatic run_random(input int n);
  for (int i = 0; i < n; i++)
  begin
    @(negedge adc_clk);
    rng_state    = xorshift(rng_state);
    adc_dat_i[0] = rng_state[15:0];
    adc_dat_i[1] = rng_state[31:16];
  end
endtask

task automatic set_pid(input logic en, input int setpoint, input int kp, input int ki);
  @(negedge adc_clk);
  for (int ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin
    pid_cfg_i[ch].enable   = en;
    pid_cfg_i[ch].setpoint = setpoint[13:0];
    pid_cfg_i[ch].kp       = kp[15:0];
    pid_cfg_i[ch].ki       = ki[15:0];
  end
endtask

task automatic set_limit(input int offset, input int lo, input int hi);
  @(negedge adc_clk);
  for (int ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin
    limit_cfg_i[ch].offset = offset[13:0];
    limit_cfg_i[ch].lo     = lo[13:0];
    limit_cfg_i[ch].hi     = hi[13:0];
  end
endtask

// integrators back to zero, full range
task automatic clear_channels();
  set_pid(1'b0, 0, 0, 0);
  set_limit(0, -8192, 8191);
  run_random(4);
endtask

task automatic wait_rail_high(input logic level, input int limit);
  int n;
  n = 0;
  while (railed_o[0].high !== level && n < limit)
  begin
    @(negedge adc_clk);
    n++;
  end
  if (railed_o[0].high !== level)
  begin
    timeout_cnt++;
    $display("timeout waiting for channel A railed high to become %0b", level);
  end
endtask

//////////////////////////////
// stimulus
//////////////////////////////

initial
begin
  rst_n_i        = 1'b0;
  adc_dat_i      = '0;
  digital_loop_i = 1'b0;
  pid_cfg_i      = '0;
  for (int ch = 0; ch < rp_sample_pkg::NUM_CH; ch++)
  begin
    limit_cfg_i[ch].offset = '0;
    limit_cfg_i[ch].lo     = rp_sample_pkg::SAMPLE_MIN;
    limit_cfg_i[ch].hi     = rp_sample_pkg::SAMPLE_MAX;
  end
  repeat (3) @(negedge adc_clk);
  rst_n_i = 1'b1;
  run_random(8);  // pipeline fill after reset

  // proportional path
  set_pid(1'b1, 0, 4096, 0);
  run_random(60);
  // offset and saturation
  set_limit(6000, -8192, 8191);
  run_random(40);
  set_limit(-6000, -8192, 8191);
  run_random(40);
  // narrow window
  set_limit(0, -500, 700);
  run_random(60);
  clear_channels();

  // anti-windup, constant zero sample
  @(negedge adc_clk);
  adc_dat_i = {2{16'h7FFC}};
  set_limit(0, -2000, 2000);
  set_pid(1'b1, 4000, 0, 64);
  wait_rail_high(1'b1, 200);
  repeat (100) @(negedge adc_clk);  // long stay on the rail
  set_pid(1'b1, -4000, 0, 64);
  wait_rail_high(1'b0, 40);  // short with anti-windup
  clear_channels();

  // digital loop with random ADC
  set_pid(1'b1, 0, 4096, 0);
  @(negedge adc_clk);
  digital_loop_i = 1'b1;
  run_random(60);
  @(negedge adc_clk);
  digital_loop_i = 1'b0;
  run_random(10);

  $display("errors: assertions %0d, timeouts %0d", UUT.i_props.fail_cnt, timeout_cnt);
  if (UUT.i_props.fail_cnt == 0 && timeout_cnt == 0)
  begin
    $display("STATUS: PASS");
  end
  else
  begin
    $display("STATUS: FAIL");
  end
  $finish;
end

endmodule
